//--- design/icache_pkg.sv
package icache_pkg;

   // bits per data word
   localparam int word_width = 32;

   // associativity, sizes the way-select field of cacop_va
   localparam int num_ways = 2;

   // controller states
   // st_idle    waits for ce or cacop_en
   // st_lookup  ways present the set read at the accepting edge
   // st_refill  line fetch from memory, one word per beat
   typedef enum logic [1:0] {
      st_idle   = 2'd0,
      st_lookup = 2'd1,
      st_refill = 2'd2
   } ctrl_state_t;

   // cache maintenance opcodes, carried on cacop_mod
   typedef enum logic [1:0] {
      // zero tag, clear valid, way picked by cacop_va
      op_store_tag        = 2'd0,
      // clear valid, way picked by cacop_va
      op_index_invalidate = 2'd1,
      // clear valid in whichever way hits
      op_hit_invalidate   = 2'd2
   } cacop_op_t;

endpackage

//--- design/cache_way.sv
`timescale 1ns/1ns

module cache_way
   import icache_pkg::*;
#(
   parameter int addr_width = 32,
   parameter int line_words = 16,
   parameter int num_sets   = 32,

   localparam int offset_width   = $clog2(line_words * word_width / 8),
   localparam int index_width    = $clog2(num_sets),
   localparam int tag_width      = addr_width - index_width - offset_width,
   localparam int byte_width     = $clog2(word_width / 8),
   localparam int word_sel_width = $clog2(line_words)
) (
   input  logic                               clk,
   input  logic                               reset,

   // lookup or write address, shared by both ways
   input  logic [addr_width-1:0]              access_addr,

   // write port from the controller
   input  logic                               way_we,
   input  logic [tag_width-1:0]               wr_tag,
   input  logic                               wr_valid,
   input  logic [line_words*word_width-1:0]   wr_line,

   // registered lookup result
   output logic                               tag_match,
   output logic [word_width-1:0]              word
);

   logic [index_width-1:0]    index;
   logic [tag_width-1:0]      access_tag;
   logic [word_sel_width-1:0] word_sel;

   // storage arrays
   logic [tag_width-1:0]                     tag_mem  [num_sets];
   logic [line_words-1:0][word_width-1:0]    line_mem [num_sets];
   logic [num_sets-1:0]                      valid_bits;

   // registered read of the addressed set
   logic [tag_width-1:0]  rd_tag;
   logic                  rd_valid;
   logic [word_width-1:0] rd_word;

   // address split
   assign word_sel   = access_addr[offset_width-1:byte_width];
   assign index      = access_addr[index_width+offset_width-1:offset_width];
   assign access_tag = access_addr[addr_width-1:index_width+offset_width];

   // valid bits, the only state that reset touches
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         rd_valid   <= 1'b0;
      end else begin
         rd_valid <= valid_bits[index];
         if (way_we) begin
            valid_bits[index] <= wr_valid;
         end
      end
   end

   // tag array, written on every way write
   always_ff @(posedge clk) begin
      rd_tag <= tag_mem[index];
      if (way_we) begin
         tag_mem[index] <= wr_tag;
      end
   end

   // line array
   // only a fill carries a line, maintenance leaves the data alone
   always_ff @(posedge clk) begin
      rd_word <= line_mem[index][word_sel];
      if (way_we && wr_valid) begin
         line_mem[index] <= wr_line;
      end
   end

   // compare against the tag the requester still holds
   assign tag_match = rd_valid && (rd_tag == access_tag);
   assign word      = rd_word;

endmodule

//--- design/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl
   import icache_pkg::*;
#(
   parameter int addr_width = 32,
   parameter int line_words = 16,
   parameter int num_sets   = 32,

   localparam int offset_width   = $clog2(line_words * word_width / 8),
   localparam int index_width    = $clog2(num_sets),
   localparam int tag_width      = addr_width - index_width - offset_width,
   localparam int byte_width     = $clog2(word_width / 8),
   localparam int word_sel_width = $clog2(line_words),
   localparam int count_width    = $clog2(line_words + 1),
   localparam int way_sel_width  = $clog2(num_ways)
) (
   input  logic                                 clk,
   input  logic                                 reset,

   // requester side
   input  logic                                 ce,
   input  logic [addr_width-1:0]                addr,
   input  logic                                 rdata_ready,
   input  logic                                 cacop_en,
   input  cacop_op_t                            cacop_mod,
   input  logic [addr_width-1:0]                cacop_va,
   output logic [word_width-1:0]                rdata,
   output logic                                 rdata_valid,
   output logic                                 icache_busy,
   output logic                                 cacop_finish,

   // memory side
   input  logic [word_width-1:0]                mem_rdata,
   input  logic                                 mem_rdata_valid,
   output logic [addr_width-1:0]                mem_addr,
   output logic                                 mem_ce,

   // way interface
   input  logic [num_ways-1:0]                  way_match,
   input  logic [num_ways-1:0][word_width-1:0]  way_word,
   output logic [addr_width-1:0]                access_addr,
   output logic [num_ways-1:0]                  way_we,
   output logic [tag_width-1:0]                 wr_tag,
   output logic                                 wr_valid,
   output logic [line_words*word_width-1:0]     wr_line
);

   ctrl_state_t state;
   ctrl_state_t state_next;

   // request fields
   logic [index_width-1:0]    req_index;
   logic [tag_width-1:0]      req_tag;
   logic [word_sel_width-1:0] req_word;
   logic [way_sel_width-1:0]  cacop_way;

   // refill bookkeeping
   logic [count_width-1:0]            beat_count;
   logic                              refill_done;
   logic [line_words*word_width-1:0]  refill_buf;
   logic [word_width-1:0]             refill_word;
   logic [addr_width-1:0]             miss_addr;

   // one replacement bit per set
   logic [num_sets-1:0] lru_bits;
   logic                victim_way;

   // qualified events
   logic hit;
   logic lookup_read;
   logic lookup_cacop;
   logic hit_accept;
   logic refill_accept;

   // maintenance uses its own address
   assign access_addr = cacop_en ? cacop_va : addr;

   assign req_word  = access_addr[offset_width-1:byte_width];
   assign req_index = access_addr[index_width+offset_width-1:offset_width];
   assign req_tag   = access_addr[addr_width-1:index_width+offset_width];
   assign cacop_way = cacop_va[way_sel_width-1:0];

   assign hit           = |way_match;
   assign lookup_read   = (state == st_lookup) && !cacop_en;
   assign lookup_cacop  = (state == st_lookup) && cacop_en;
   assign refill_done   = (beat_count == count_width'(line_words));
   assign hit_accept    = lookup_read && hit && rdata_ready;
   assign refill_accept = (state == st_refill) && refill_done && rdata_ready;
   assign victim_way    = lru_bits[req_index];

   // state register
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         state <= state_next;
      end
   end

   // next state
   always_comb begin
      state_next = state;
      case (state)
         st_idle: begin
            if (ce || cacop_en) begin
               state_next = st_lookup;
            end
         end
         st_lookup: begin
            if (cacop_en) begin
               state_next = st_idle;
            end else if (hit) begin
               // hold here while the requester stalls
               if (rdata_ready) begin
                  state_next = st_idle;
               end
            end else begin
               state_next = st_refill;
            end
         end
         st_refill: begin
            if (refill_done && rdata_ready) begin
               state_next = st_idle;
            end
         end
         default: state_next = st_idle;
      endcase
   end

   // beat counter, cleared while looking up
   always_ff @(posedge clk) begin
      if (reset) begin
         beat_count <= '0;
      end else if (state == st_lookup) begin
         beat_count <= '0;
      end else if (mem_ce && mem_rdata_valid) begin
         beat_count <= beat_count + 1'b1;
      end
   end

   // beats shift in from the top, so beat k lands in word k
   always_ff @(posedge clk) begin
      if (mem_ce && mem_rdata_valid) begin
         refill_buf <= {mem_rdata, refill_buf[line_words*word_width-1:word_width]};
      end
   end

   // line-aligned fetch address
   always_ff @(posedge clk) begin
      if (lookup_read) begin
         miss_addr <= {addr[addr_width-1:offset_width], {offset_width{1'b0}}};
      end
   end

   // replacement bits
   always_ff @(posedge clk) begin
      if (reset) begin
         lru_bits <= '0;
      end else if (hit_accept) begin
         // hit in way 0 makes way 1 the next victim, and the reverse
         lru_bits[req_index] <= way_match[0];
      end else if (refill_accept) begin
         lru_bits[req_index] <= ~victim_way;
      end
   end

   // way write enables
   always_comb begin
      way_we = '0;
      if (lookup_cacop) begin
         case (cacop_mod)
            op_store_tag,
            op_index_invalidate: way_we[cacop_way] = 1'b1;
            op_hit_invalidate:   way_we = way_match;
            default:             way_we = '0;
         endcase
      end else if (refill_accept) begin
         way_we[victim_way] = 1'b1;
      end
   end

   assign wr_tag   = (lookup_cacop && (cacop_mod == op_store_tag)) ? '0 : req_tag;
   assign wr_valid = !lookup_cacop;
   assign wr_line  = refill_buf;

   // read data select
   assign refill_word = refill_buf[req_word*word_width +: word_width];

   always_comb begin
      rdata = refill_word;
      if (state != st_refill) begin
         rdata = way_word[0];
         for (int w = 1; w < num_ways; w++) begin
            if (way_match[w]) begin
               rdata = way_word[w];
            end
         end
      end
   end

   assign rdata_valid  = (lookup_read && hit) || ((state == st_refill) && refill_done);
   assign cacop_finish = lookup_cacop;
   assign icache_busy  = (state != st_idle);

   // memory request
   assign mem_ce   = (state == st_refill) && !refill_done;
   assign mem_addr = miss_addr;

endmodule

//--- design/icache_top.sv
`timescale 1ns/1ns

module icache_top
   import icache_pkg::*;
#(
   parameter int addr_width = 32,
   parameter int line_words = 16,
   parameter int num_sets   = 32,

   localparam int offset_width = $clog2(line_words * word_width / 8),
   localparam int index_width  = $clog2(num_sets),
   localparam int tag_width    = addr_width - index_width - offset_width
) (
   input  logic                    clk,
   input  logic                    reset,

   // fetch request
   input  logic                    ce,
   input  logic [addr_width-1:0]   addr,
   output logic [word_width-1:0]   rdata,
   output logic                    rdata_valid,
   input  logic                    rdata_ready,
   output logic                    icache_busy,

   // maintenance
   input  logic                    cacop_en,
   input  cacop_op_t               cacop_mod,
   input  logic [addr_width-1:0]   cacop_va,
   output logic                    cacop_finish,

   // line fetch from memory
   output logic [addr_width-1:0]   mem_addr,
   output logic                    mem_ce,
   input  logic [word_width-1:0]   mem_rdata,
   input  logic                    mem_rdata_valid
);

   logic [addr_width-1:0]                access_addr;
   logic [num_ways-1:0]                  way_we;
   logic [tag_width-1:0]                 wr_tag;
   logic                                 wr_valid;
   logic [line_words*word_width-1:0]     wr_line;
   logic [num_ways-1:0]                  way_match;
   logic [num_ways-1:0][word_width-1:0]  way_word;

   cache_way #(
      .addr_width (addr_width),
      .line_words (line_words),
      .num_sets   (num_sets)
   ) way0_inst (
      .clk         (clk),
      .reset       (reset),
      .access_addr (access_addr),
      .way_we      (way_we[0]),
      .wr_tag      (wr_tag),
      .wr_valid    (wr_valid),
      .wr_line     (wr_line),
      .tag_match   (way_match[0]),
      .word        (way_word[0])
   );

   cache_way #(
      .addr_width (addr_width),
      .line_words (line_words),
      .num_sets   (num_sets)
   ) way1_inst (
      .clk         (clk),
      .reset       (reset),
      .access_addr (access_addr),
      .way_we      (way_we[1]),
      .wr_tag      (wr_tag),
      .wr_valid    (wr_valid),
      .wr_line     (wr_line),
      .tag_match   (way_match[1]),
      .word        (way_word[1])
   );

   cache_ctrl #(
      .addr_width (addr_width),
      .line_words (line_words),
      .num_sets   (num_sets)
   ) cache_ctrl_inst (
      .clk             (clk),
      .reset           (reset),
      .ce              (ce),
      .addr            (addr),
      .rdata_ready     (rdata_ready),
      .cacop_en        (cacop_en),
      .cacop_mod       (cacop_mod),
      .cacop_va        (cacop_va),
      .rdata           (rdata),
      .rdata_valid     (rdata_valid),
      .icache_busy     (icache_busy),
      .cacop_finish    (cacop_finish),
      .mem_rdata       (mem_rdata),
      .mem_rdata_valid (mem_rdata_valid),
      .mem_addr        (mem_addr),
      .mem_ce          (mem_ce),
      .way_match       (way_match),
      .way_word        (way_word),
      .access_addr     (access_addr),
      .way_we          (way_we),
      .wr_tag          (wr_tag),
      .wr_valid        (wr_valid),
      .wr_line         (wr_line)
   );

endmodule

//--- testbench/tb_line_memory.sv
`timescale 1ns/1ns

module tb_line_memory
   import icache_pkg::*;
#(
   parameter int addr_width = 32,
   parameter int rand_seed  = 1
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  mem_ce,
   input  logic [addr_width-1:0] mem_addr,
   output logic [word_width-1:0] mem_rdata,
   output logic                  mem_rdata_valid
);

   int unsigned beat;
   int unsigned gap;

   // the word at byte address a is the inverse of a
   initial begin
      mem_rdata       = '0;
      mem_rdata_valid = 1'b0;
      beat            = 0;
      gap             = 0;
      void'($urandom(rand_seed));
      forever begin
         @(negedge clk);
         // a beat shown last cycle was counted at the rising edge
         if (mem_rdata_valid) begin
            beat = beat + 1;
         end
         mem_rdata_valid = 1'b0;
         if (reset || !mem_ce) begin
            beat = 0;
            gap  = 0;
         end else if (gap != 0) begin
            gap = gap - 1;
         end else begin
            mem_rdata       = word_width'(~(mem_addr + addr_width'(4 * beat)));
            mem_rdata_valid = 1'b1;
            // up to two idle cycles before the next beat
            gap = $urandom % 3;
         end
      end
   end

endmodule

//--- testbench/icache_chk.sv
`timescale 1ns/1ns

module icache_chk
   import icache_pkg::*;
#(
   parameter int addr_width = 32,
   parameter int line_words = 16
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  ce,
   input  logic [addr_width-1:0] addr,
   input  logic [word_width-1:0] rdata,
   input  logic                  rdata_valid,
   input  logic                  rdata_ready,
   input  logic                  icache_busy,
   input  logic                  cacop_en,
   input  logic                  cacop_finish,
   input  logic [addr_width-1:0] mem_addr,
   input  logic                  mem_ce
);

   localparam int line_bytes = line_words * word_width / 8;

   logic fail_seen = 1'b0;
   logic read_accept;
   logic cacop_accept;

   assign read_accept  = ce && !cacop_en && !icache_busy;
   assign cacop_accept = cacop_en && !icache_busy;

   reset_quiet: assert property (@(posedge clk)
      reset |=> !rdata_valid && !mem_ce && !cacop_finish && !icache_busy)
      else begin
         $error("Fail %0t ns: outputs active after reset", $time);
         fail_seen = 1'b1;
      end

   // memory holds the inverse of each address
   read_data: assert property (@(posedge clk) disable iff (reset)
      rdata_valid |-> rdata == word_width'(~addr))
      else begin
         $error("Fail %0t ns: rdata is not the word at addr", $time);
         fail_seen = 1'b1;
      end

   // fetch starts at the first byte of the line
   line_fetch: assert property (@(posedge clk) disable iff (reset)
      mem_ce |-> mem_addr == (addr & ~addr_width'(line_bytes - 1)))
      else begin
         $error("Fail %0t ns: mem_addr is not the line address", $time);
         fail_seen = 1'b1;
      end

   // a lookup without data has to start a refill
   miss_refill: assert property (@(posedge clk) disable iff (reset)
      read_accept ##1 !rdata_valid |=> mem_ce)
      else begin
         $error("Fail %0t ns: miss without mem_ce", $time);
         fail_seen = 1'b1;
      end

   cacop_pulse: assert property (@(posedge clk) disable iff (reset)
      cacop_accept |=> cacop_finish ##1 !cacop_finish)
      else begin
         $error("Fail %0t ns: cacop_finish is not a pulse one cycle after cacop_en", $time);
         fail_seen = 1'b1;
      end

   read_hold: assert property (@(posedge clk) disable iff (reset)
      rdata_valid && !rdata_ready |=> rdata_valid && $stable(rdata))
      else begin
         $error("Fail %0t ns: read data dropped under back-pressure", $time);
         fail_seen = 1'b1;
      end

endmodule

//--- testbench/tb_icache.sv
`timescale 1ns/1ns

module tb_icache
   import icache_pkg::*;
();

   localparam int addr_width = 32;
   localparam int line_words = 16;
   localparam int num_sets   = 32;
   localparam int wait_limit = 200;

   // set 3 with tags 1 to 3, then sets 5 and 7
   localparam logic [31:0] line_a = 32'h0000_08c0;
   localparam logic [31:0] line_b = 32'h0000_10c0;
   localparam logic [31:0] line_c = 32'h0000_18c0;
   localparam logic [31:0] line_d = 32'h0000_0940;
   localparam logic [31:0] line_e = 32'h0000_09c0;

   logic                  clk;
   logic                  reset;
   logic                  ce;
   logic [addr_width-1:0] addr;
   logic [word_width-1:0] rdata;
   logic                  rdata_valid;
   logic                  rdata_ready;
   logic                  icache_busy;
   logic                  cacop_en;
   cacop_op_t             cacop_mod;
   logic [addr_width-1:0] cacop_va;
   logic                  cacop_finish;
   logic [addr_width-1:0] mem_addr;
   logic                  mem_ce;
   logic [word_width-1:0] mem_rdata;
   logic                  mem_rdata_valid;

   icache_top #(
      .addr_width (addr_width),
      .line_words (line_words),
      .num_sets   (num_sets)
   ) icache_top_inst (.*);

   tb_line_memory #(
      .addr_width (addr_width),
      .rand_seed  (79)
   ) line_memory_inst (.*);

   bind icache_top icache_chk #(
      .addr_width (addr_width),
      .line_words (line_words)
   ) icache_chk_inst (.*);

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "run stopped");
   endtask

   // one fetch, optionally holding rdata_ready low for stall cycles
   task automatic read_word(input logic [31:0] a, input bit expect_hit, input int stall);
      int cycles;
      bit refilled;
      cycles      = 0;
      refilled    = 1'b0;
      ce          = 1'b1;
      addr        = a;
      rdata_ready = (stall == 0);
      @(negedge clk);
      hit_latency: assert (!expect_hit || rdata_valid)
         else abort_run($sformatf("Fail %0t ns: no hit one cycle after ce at %h", $time, a));
      while (!rdata_valid) begin
         if (mem_ce) begin
            refilled = 1'b1;
         end
         cycles++;
         if (cycles > wait_limit) begin
            abort_run($sformatf("timeout waiting for read data at address %h", a));
         end
         @(negedge clk);
      end
      hit_or_miss: assert (expect_hit != refilled)
         else abort_run($sformatf("Fail %0t ns: expected hit %0d, refill %0d at %h",
                                  $time, expect_hit, refilled, a));
      repeat (stall) @(negedge clk);
      rdata_ready = 1'b1;
      @(negedge clk);
      ce = 1'b0;
   endtask

   task automatic run_cacop(input cacop_op_t op, input logic [31:0] va);
      cacop_en  = 1'b1;
      cacop_mod = op;
      cacop_va  = va;
      @(negedge clk);
      finish_pulse: assert (cacop_finish)
         else abort_run($sformatf("Fail %0t ns: no cacop_finish for %s", $time, op.name()));
      @(negedge clk);
      cacop_en = 1'b0;
   endtask

   always @(negedge clk) begin
      if (icache_top_inst.icache_chk_inst.fail_seen) begin
         abort_run("an assertion in the checker failed");
      end
   end

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      reset       = 1'b1;
      ce          = 1'b0;
      addr        = '0;
      rdata_ready = 1'b1;
      cacop_en    = 1'b0;
      cacop_mod   = op_store_tag;
      cacop_va    = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      // cold miss, then another word of the same line
      read_word(line_a + 32'h08, 1'b0, 0);
      read_word(line_a + 32'h3c, 1'b1, 0);

      // A B A C in set 3, C takes the way of B
      read_word(line_b + 32'h04, 1'b0, 0);
      read_word(line_a + 32'h10, 1'b1, 0);
      read_word(line_c + 32'h20, 1'b0, 0);
      read_word(line_a + 32'h14, 1'b1, 0);
      read_word(line_c + 32'h00, 1'b1, 0);
      read_word(line_b + 32'h04, 1'b0, 0);

      // set 5, way select in bit 0 of cacop_va
      read_word(line_d, 1'b0, 0);
      run_cacop(op_index_invalidate, line_d);
      read_word(line_d + 32'h04, 1'b0, 0);
      run_cacop(op_hit_invalidate, line_d);
      read_word(line_d + 32'h08, 1'b0, 0);
      run_cacop(op_store_tag, line_d);
      read_word(line_d + 32'h0c, 1'b0, 0);

      // stalled requester on a hit and on a refill
      read_word(line_c + 32'h30, 1'b1, 4);
      read_word(line_e + 32'h18, 1'b0, 3);

      @(negedge clk);
      if (icache_top_inst.icache_chk_inst.fail_seen) begin
         abort_run("an assertion in the checker failed");
      end else begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

//--- build.f
design/icache_pkg.sv
design/cache_way.sv
design/cache_ctrl.sv
design/icache_top.sv
testbench/tb_line_memory.sv
testbench/icache_chk.sv
testbench/tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - files:
      - design/icache_pkg.sv
      - design/cache_way.sv
      - design/cache_ctrl.sv
      - design/icache_top.sv

  - target: test
    files:
      - testbench/tb_line_memory.sv
      - testbench/icache_chk.sv
      - testbench/tb_icache.sv
